// File: core_ctrl.f
+incdir+verification
hdl/ctrl_pkg.sv
hdl/wb_event_decode.sv
hdl/debug_request_tracker.sv
hdl/pipeline_ctrl_fsm.sv
hdl/core_ctrl_top.sv
verification/core_ctrl_tb.sv

// File: hdl/core_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_ctrl_top import ctrl_pkg::*; #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  fetch_enable_i,

  // ID and EX stage
  input  wire                  jr_stall_i,
  input  wire                  load_stall_i,
  input  wire                  csr_stall_i,
  input  wire                  jump_id_i,
  input  wire                  mret_id_i,
  input  wire                  if_instr_valid_i,
  input  wire                  id_instr_valid_i,
  input  wire                  ex_instr_valid_i,
  input  wire                  branch_ex_i,
  input  wire                  if_valid_i,
  input  wire                  id_ready_i,
  input  wire                  ex_valid_i,
  input  wire                  wb_ready_i,
  input  wire                  data_req_i,

  // WB stage
  input  wire                  wb_instr_valid_i,
  input  wire                  wb_illegal_i,
  input  wire                  wb_ecall_i,
  input  wire                  wb_ebreak_i,
  input  wire                  wb_wfi_i,
  input  wire                  wb_mret_i,
  input  wire                  wb_dret_i,
  input  wire                  wb_lsu_en_i,

  // Interrupts and debug
  input  wire                  irq_req_i,
  input  wire [IRQ_ID_W-1:0]   irq_id_i,
  input  wire                  irq_wake_i,
  input  wire                  debug_req_i,
  input  wire                  debug_ebreakm_i,

  output logic                 instr_req_o,
  output logic                 ctrl_busy_o,
  output logic                 pc_set_o,
  output pc_mux_e              pc_mux_o,
  output exc_pc_mux_e          exc_pc_mux_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o,
  output logic                 halt_ex_o,
  output logic                 halt_wb_o,
  output logic                 kill_if_o,
  output logic                 kill_id_o,
  output logic                 kill_ex_o,
  output logic                 kill_wb_o,
  output logic                 irq_ack_o,
  output logic [IRQ_ID_W-1:0]  irq_id_o,
  output logic                 csr_save_cause_o,
  output logic [IRQ_ID_W:0]    csr_cause_o,
  output logic                 csr_save_if_o,
  output logic                 csr_save_id_o,
  output logic                 csr_save_ex_o,
  output logic                 csr_save_wb_o,
  output logic                 csr_restore_mret_o,
  output logic                 csr_restore_dret_o,
  output logic                 debug_csr_save_o,
  output logic                 debug_mode_o,
  output logic [2:0]           debug_cause_o,
  output logic                 debug_havereset_o,
  output logic                 debug_running_o,
  output logic                 debug_halted_o
);

  // WB events
  logic               exception;
  logic [CAUSE_W-1:0] exception_cause;
  logic               wfi;
  logic               mret;
  logic               dret;
  logic               ebreak;
  logic               lsu_in_wb;

  // Tracker to FSM
  logic               pending_debug;
  logic               debug_allowed;
  logic               interrupt_allowed;
  logic               pending_irq;

  // FSM to tracker
  logic               debug_mode_next;
  logic               boot;

  wb_event_decode u_wb_event_decode (
    .wb_instr_valid_i  (wb_instr_valid_i),
    .wb_illegal_i      (wb_illegal_i),
    .wb_ecall_i        (wb_ecall_i),
    .wb_ebreak_i       (wb_ebreak_i),
    .wb_wfi_i          (wb_wfi_i),
    .wb_mret_i         (wb_mret_i),
    .wb_dret_i         (wb_dret_i),
    .wb_lsu_en_i       (wb_lsu_en_i),
    .exception_o       (exception),
    .exception_cause_o (exception_cause),
    .wfi_o             (wfi),
    .mret_o            (mret),
    .dret_o            (dret),
    .ebreak_o          (ebreak),
    .lsu_in_wb_o       (lsu_in_wb)
  );

  debug_request_tracker u_debug_request_tracker (
    .clk                 (clk),
    .rst_n               (rst_n),
    .debug_req_i         (debug_req_i),
    .debug_ebreakm_i     (debug_ebreakm_i),
    .irq_req_i           (irq_req_i),
    .data_req_i          (data_req_i),
    .ex_valid_i          (ex_valid_i),
    .wb_ready_i          (wb_ready_i),
    .lsu_in_wb_i         (lsu_in_wb),
    .ebreak_i            (ebreak),
    .debug_mode_i        (debug_mode_o),
    .debug_mode_next_i   (debug_mode_next),
    .boot_i              (boot),
    .pending_debug_o     (pending_debug),
    .debug_allowed_o     (debug_allowed),
    .interrupt_allowed_o (interrupt_allowed),
    .pending_irq_o       (pending_irq),
    .debug_cause_o       (debug_cause_o),
    .debug_havereset_o   (debug_havereset_o),
    .debug_running_o     (debug_running_o),
    .debug_halted_o      (debug_halted_o)
  );

  pipeline_ctrl_fsm #(
    .IRQ_ID_W (IRQ_ID_W)
  ) u_pipeline_ctrl_fsm (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_enable_i      (fetch_enable_i),
    .jr_stall_i          (jr_stall_i),
    .load_stall_i        (load_stall_i),
    .csr_stall_i         (csr_stall_i),
    .jump_id_i           (jump_id_i),
    .mret_id_i           (mret_id_i),
    .if_instr_valid_i    (if_instr_valid_i),
    .id_instr_valid_i    (id_instr_valid_i),
    .ex_instr_valid_i    (ex_instr_valid_i),
    .branch_ex_i         (branch_ex_i),
    .if_valid_i          (if_valid_i),
    .id_ready_i          (id_ready_i),
    .irq_id_i            (irq_id_i),
    .irq_wake_i          (irq_wake_i),
    .exception_i         (exception),
    .exception_cause_i   (exception_cause),
    .wfi_i               (wfi),
    .mret_i              (mret),
    .dret_i              (dret),
    .ebreak_i            (ebreak),
    .pending_debug_i     (pending_debug),
    .debug_allowed_i     (debug_allowed),
    .interrupt_allowed_i (interrupt_allowed),
    .pending_irq_i       (pending_irq),
    .debug_cause_i       (debug_cause_o),
    .instr_req_o         (instr_req_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_pc_mux_o        (exc_pc_mux_o),
    .halt_if_o           (halt_if_o),
    .halt_id_o           (halt_id_o),
    .halt_ex_o           (halt_ex_o),
    .halt_wb_o           (halt_wb_o),
    .kill_if_o           (kill_if_o),
    .kill_id_o           (kill_id_o),
    .kill_ex_o           (kill_ex_o),
    .kill_wb_o           (kill_wb_o),
    .irq_ack_o           (irq_ack_o),
    .irq_id_o            (irq_id_o),
    .csr_save_cause_o    (csr_save_cause_o),
    .csr_cause_o         (csr_cause_o),
    .csr_save_if_o       (csr_save_if_o),
    .csr_save_id_o       (csr_save_id_o),
    .csr_save_ex_o       (csr_save_ex_o),
    .csr_save_wb_o       (csr_save_wb_o),
    .csr_restore_mret_o  (csr_restore_mret_o),
    .csr_restore_dret_o  (csr_restore_dret_o),
    .debug_csr_save_o    (debug_csr_save_o),
    .debug_mode_o        (debug_mode_o),
    .debug_mode_next_o   (debug_mode_next),
    .boot_o              (boot)
  );

endmodule

`default_nettype wire

// File: hdl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  //////////////////////////////
  // FSM encodings
  //////////////////////////////

  // Main controller states
  typedef enum logic [2:0] {
    RESET       = 3'b000,
    BOOT_SET    = 3'b001,
    FUNCTIONAL  = 3'b010,
    SLEEP       = 3'b011,
    DEBUG_TAKEN = 3'b100
  } ctrl_state_e;

  // Debug status, one bit per state
  typedef enum logic [2:0] {
    HAVERESET = 3'b001,
    RUNNING   = 3'b010,
    HALTED    = 3'b100
  } debug_state_e;

  //////////////////////////////
  // PC selection
  //////////////////////////////

  // Source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b001,
    PC_BRANCH    = 3'b010,
    PC_MRET      = 3'b011,
    PC_DRET      = 3'b100,
    PC_EXCEPTION = 3'b101
  } pc_mux_e;

  // Vector used when PC_EXCEPTION is selected
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00,
    EXC_PC_IRQ       = 2'b01,
    // Debug entry
    EXC_PC_DBD       = 2'b10,
    // Exception while in debug mode
    EXC_PC_DBE       = 2'b11
  } exc_pc_mux_e;

  //////////////////////////////
  // Cause codes
  //////////////////////////////

  localparam int unsigned CAUSE_W = 5;

  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ILLEGAL_INSN = 5'd2;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_BREAKPOINT   = 5'd3;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ECALL_MMODE  = 5'd11;

  // dcsr.cause values
  localparam logic [2:0] DBG_CAUSE_NONE    = 3'd0;
  localparam logic [2:0] DBG_CAUSE_EBREAK  = 3'd1;
  localparam logic [2:0] DBG_CAUSE_HALTREQ = 3'd3;

endpackage

`default_nettype wire

// File: hdl/debug_request_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module debug_request_tracker import ctrl_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,

  input  wire        debug_req_i,
  // dcsr.ebreakm
  input  wire        debug_ebreakm_i,
  input  wire        irq_req_i,
  // LSU bus request and EX to WB handshake
  input  wire        data_req_i,
  input  wire        ex_valid_i,
  input  wire        wb_ready_i,
  input  wire        lsu_in_wb_i,
  input  wire        ebreak_i,

  // From the main FSM
  input  wire        debug_mode_i,
  input  wire        debug_mode_next_i,
  input  wire        boot_i,

  output logic       pending_debug_o,
  output logic       debug_allowed_o,
  output logic       interrupt_allowed_o,
  output logic       pending_irq_o,
  output logic [2:0] debug_cause_o,
  output logic       debug_havereset_o,
  output logic       debug_running_o,
  output logic       debug_halted_o
);

  logic         debug_req_q;
  logic         data_req_q;
  logic         ex_to_wb;
  logic         ebreak_to_debug;
  logic [2:0]   debug_cause_n;
  debug_state_e debug_fsm_cs;
  debug_state_e debug_fsm_ns;

  //////////////////////////////
  // Request flops
  //////////////////////////////

  assign ex_to_wb = ex_valid_i && wb_ready_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      debug_req_q   <= 1'b0;
      data_req_q    <= 1'b0;
      debug_cause_o <= DBG_CAUSE_NONE;
    end else begin
      // Sticky halt request, dropped once debug mode is reached
      if (debug_req_i) begin
        debug_req_q <= 1'b1;
      end else if (debug_mode_i) begin
        debug_req_q <= 1'b0;
      end
      // Bus request issued while the LSU instruction is still in EX
      if (data_req_i && !ex_to_wb) begin
        data_req_q <= 1'b1;
      end else if (ex_to_wb) begin
        data_req_q <= 1'b0;
      end
      // Sampled every cycle, read back in DEBUG_TAKEN
      debug_cause_o <= debug_cause_n;
    end
  end

  //////////////////////////////
  // Pending and allowed
  //////////////////////////////

  assign ebreak_to_debug = ebreak_i && debug_ebreakm_i && !debug_mode_i;

  // Ebreak inside debug mode restarts at the halt address
  assign pending_debug_o = ((debug_req_i || debug_req_q) && !debug_mode_i) ||
                           ebreak_to_debug || (ebreak_i && debug_mode_i);

  // No load/store may be cut off once its bus request went out
  assign debug_allowed_o     = !lsu_in_wb_i && !data_req_q;
  assign interrupt_allowed_o = !lsu_in_wb_i && !data_req_q && !debug_mode_i;
  assign pending_irq_o       = irq_req_i && !debug_mode_i;

  assign debug_cause_n = ebreak_to_debug ? DBG_CAUSE_EBREAK : DBG_CAUSE_HALTREQ;

  //////////////////////////////
  // Debug status FSM
  //////////////////////////////

  always_comb begin
    debug_fsm_ns = debug_fsm_cs;
    case (debug_fsm_cs)
      HAVERESET: if (boot_i) debug_fsm_ns = RUNNING;
      RUNNING:   if (debug_mode_next_i) debug_fsm_ns = HALTED;
      HALTED:    if (!debug_mode_next_i) debug_fsm_ns = RUNNING;
      default:   debug_fsm_ns = HAVERESET;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      debug_fsm_cs <= HAVERESET;
    end else begin
      debug_fsm_cs <= debug_fsm_ns;
    end
  end

  assign debug_havereset_o = (debug_fsm_cs == HAVERESET);
  assign debug_running_o   = (debug_fsm_cs == RUNNING);
  assign debug_halted_o    = (debug_fsm_cs == HALTED);

  // Exactly one status line towards the debug module at any time
  a_status_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot(debug_fsm_cs));

endmodule

`default_nettype wire

// File: hdl/pipeline_ctrl_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_ctrl_fsm import ctrl_pkg::*; #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  fetch_enable_i,

  // Hazard stalls
  input  wire                  jr_stall_i,
  input  wire                  load_stall_i,
  input  wire                  csr_stall_i,

  // Control transfers
  input  wire                  jump_id_i,
  input  wire                  mret_id_i,
  // Valid bits of the IF/ID, ID/EX and EX/WB pipeline registers
  input  wire                  if_instr_valid_i,
  input  wire                  id_instr_valid_i,
  input  wire                  ex_instr_valid_i,
  // Branch in EX with a taken decision
  input  wire                  branch_ex_i,
  input  wire                  if_valid_i,
  input  wire                  id_ready_i,

  // Interrupt controller
  input  wire [IRQ_ID_W-1:0]   irq_id_i,
  input  wire                  irq_wake_i,

  // WB events
  input  wire                  exception_i,
  input  wire [CAUSE_W-1:0]    exception_cause_i,
  input  wire                  wfi_i,
  input  wire                  mret_i,
  input  wire                  dret_i,
  input  wire                  ebreak_i,

  // Debug and interrupt tracking
  input  wire                  pending_debug_i,
  input  wire                  debug_allowed_i,
  input  wire                  interrupt_allowed_i,
  input  wire                  pending_irq_i,
  input  wire [2:0]            debug_cause_i,

  output logic                 instr_req_o,
  output logic                 ctrl_busy_o,
  output logic                 pc_set_o,
  output pc_mux_e              pc_mux_o,
  output exc_pc_mux_e          exc_pc_mux_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o,
  output logic                 halt_ex_o,
  output logic                 halt_wb_o,
  output logic                 kill_if_o,
  output logic                 kill_id_o,
  output logic                 kill_ex_o,
  output logic                 kill_wb_o,
  output logic                 irq_ack_o,
  output logic [IRQ_ID_W-1:0]  irq_id_o,
  output logic                 csr_save_cause_o,
  output logic [IRQ_ID_W:0]    csr_cause_o,
  output logic                 csr_save_if_o,
  output logic                 csr_save_id_o,
  output logic                 csr_save_ex_o,
  output logic                 csr_save_wb_o,
  output logic                 csr_restore_mret_o,
  output logic                 csr_restore_dret_o,
  output logic                 debug_csr_save_o,
  output logic                 debug_mode_o,
  output logic                 debug_mode_next_o,
  output logic                 boot_o
);

  ctrl_state_e ctrl_fsm_cs;
  ctrl_state_e ctrl_fsm_ns;
  logic        taken_q;
  logic        taken_n;
  logic        jump_taken_id;
  logic        branch_taken_ex;

  // Jump or mret in ID, blocked once a transfer was already taken
  assign jump_taken_id = ((jump_id_i && !jr_stall_i) || (mret_id_i && !csr_stall_i)) &&
                         if_instr_valid_i && !taken_q;
  assign branch_taken_ex = branch_ex_i && id_instr_valid_i && !taken_q;

  assign boot_o = (ctrl_fsm_cs == BOOT_SET);

  //////////////////////////////
  // Next state and outputs
  //////////////////////////////

  always_comb begin
    ctrl_fsm_ns        = ctrl_fsm_cs;
    instr_req_o        = 1'b1;
    ctrl_busy_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_IRQ;
    halt_if_o          = 1'b0;
    // Stalls, and a bubble while a request waits to become allowed
    halt_id_o          = jr_stall_i || load_stall_i || csr_stall_i ||
                         (pending_irq_i && !interrupt_allowed_i) ||
                         (pending_debug_i && !debug_allowed_i);
    halt_ex_o          = 1'b0;
    halt_wb_o          = 1'b0;
    kill_if_o          = 1'b0;
    kill_id_o          = 1'b0;
    kill_ex_o          = 1'b0;
    kill_wb_o          = 1'b0;
    irq_ack_o          = 1'b0;
    irq_id_o           = '0;
    csr_save_cause_o   = 1'b0;
    csr_cause_o        = '0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_ex_o      = 1'b0;
    csr_save_wb_o      = 1'b0;
    csr_restore_mret_o = 1'b0;
    csr_restore_dret_o = 1'b0;
    debug_csr_save_o   = 1'b0;
    debug_mode_next_o  = debug_mode_o;
    taken_n            = taken_q;

    case (ctrl_fsm_cs)
      RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          ctrl_fsm_ns = BOOT_SET;
        end
      end
      // Extra state keeps fetch_enable_i off the PC path
      BOOT_SET: begin
        pc_set_o    = 1'b1;
        pc_mux_o    = PC_BOOT;
        ctrl_fsm_ns = FUNCTIONAL;
      end
      FUNCTIONAL: begin
        if (pending_debug_i && debug_allowed_i) begin
          // Freeze everything, the jump happens in DEBUG_TAKEN
          halt_if_o   = 1'b1;
          halt_id_o   = 1'b1;
          halt_ex_o   = 1'b1;
          halt_wb_o   = 1'b1;
          ctrl_fsm_ns = DEBUG_TAKEN;
        end else if (pending_irq_i && interrupt_allowed_i) begin
          kill_if_o        = 1'b1;
          kill_id_o        = 1'b1;
          kill_ex_o        = 1'b1;
          kill_wb_o        = 1'b1;
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXCEPTION;
          exc_pc_mux_o     = EXC_PC_IRQ;
          irq_ack_o        = 1'b1;
          irq_id_o         = irq_id_i;
          csr_save_cause_o = 1'b1;
          // Top bit marks an interrupt in mcause
          csr_cause_o      = {1'b1, irq_id_i};
          // mepc gets the oldest valid PC
          if (ex_instr_valid_i) csr_save_wb_o = 1'b1;
          else if (id_instr_valid_i) csr_save_ex_o = 1'b1;
          else if (if_instr_valid_i) csr_save_id_o = 1'b1;
          else csr_save_if_o = 1'b1;
        end else begin
          if (exception_i) begin
            // WB write enables are already suppressed
            kill_if_o        = 1'b1;
            kill_id_o        = 1'b1;
            kill_ex_o        = 1'b1;
            pc_set_o         = 1'b1;
            pc_mux_o         = PC_EXCEPTION;
            exc_pc_mux_o     = debug_mode_o ? EXC_PC_DBE : EXC_PC_EXCEPTION;
            csr_save_wb_o    = 1'b1;
            // CSRs stay untouched in debug mode
            csr_save_cause_o = !debug_mode_o;
            csr_cause_o      = (IRQ_ID_W+1)'(exception_cause_i);
          end else if (wfi_i) begin
            // EX and WB keep moving so the pipe drains
            halt_if_o   = 1'b1;
            halt_id_o   = 1'b1;
            instr_req_o = 1'b0;
            ctrl_fsm_ns = SLEEP;
          end else if (dret_i) begin
            kill_if_o          = 1'b1;
            kill_id_o          = 1'b1;
            kill_ex_o          = 1'b1;
            pc_set_o           = 1'b1;
            pc_mux_o           = PC_DRET;
            csr_restore_dret_o = 1'b1;
            debug_mode_next_o  = 1'b0;
          end else if (branch_taken_ex) begin
            kill_if_o = 1'b1;
            kill_id_o = 1'b1;
            pc_set_o  = 1'b1;
            pc_mux_o  = PC_BRANCH;
            taken_n   = 1'b1;
          end else if (jump_taken_id) begin
            kill_if_o = 1'b1;
            pc_set_o  = 1'b1;
            if (mret_id_i) begin
              // mret in debug mode goes to the debug exception vector
              pc_mux_o     = debug_mode_o ? PC_EXCEPTION : PC_MRET;
              exc_pc_mux_o = EXC_PC_DBE;
            end else begin
              pc_mux_o = PC_JUMP;
            end
            taken_n = 1'b1;
          end
          // mret reaching WB restores mstatus
          csr_restore_mret_o = mret_i && !debug_mode_o;
        end
      end
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        // Halting WB holds the whole pipe
        halt_wb_o   = 1'b1;
        if (irq_wake_i || pending_debug_i || debug_mode_o) begin
          ctrl_fsm_ns = FUNCTIONAL;
        end
      end
      DEBUG_TAKEN: begin
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXCEPTION;
        exc_pc_mux_o     = EXC_PC_DBD;
        // No dcsr/dpc update for ebreak inside debug mode
        csr_save_cause_o = !(ebreak_i && debug_mode_o);
        debug_csr_save_o = 1'b1;
        kill_if_o        = 1'b1;
        kill_id_o        = 1'b1;
        kill_ex_o        = 1'b1;
        // The ebreak that caused entry retires
        kill_wb_o        = !((debug_cause_i == DBG_CAUSE_EBREAK) || (debug_mode_o && ebreak_i));
        if (ex_instr_valid_i) csr_save_wb_o = 1'b1;
        else if (id_instr_valid_i) csr_save_ex_o = 1'b1;
        else if (if_instr_valid_i) csr_save_id_o = 1'b1;
        else csr_save_if_o = 1'b1;
        debug_mode_next_o = 1'b1;
        ctrl_fsm_ns       = FUNCTIONAL;
      end
      default: begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = RESET;
      end
    endcase

    // New instruction leaves IF, a fresh transfer is allowed again
    if (taken_q && if_valid_i && id_ready_i) begin
      taken_n = 1'b0;
    end
  end

  //////////////////////////////
  // Flops
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ctrl_fsm_cs  <= RESET;
      taken_q      <= 1'b0;
      debug_mode_o <= 1'b0;
    end else begin
      ctrl_fsm_cs  <= ctrl_fsm_ns;
      taken_q      <= taken_n;
      debug_mode_o <= debug_mode_next_o;
    end
  end

  // Strobes only come from states that own the fetch address
  a_irq_ack_state: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_o |-> (ctrl_fsm_cs inside {FUNCTIONAL, BOOT_SET, DEBUG_TAKEN}));
  a_pc_set_state: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_o |-> (ctrl_fsm_cs inside {FUNCTIONAL, BOOT_SET, DEBUG_TAKEN}));

endmodule

`default_nettype wire

// File: hdl/wb_event_decode.sv
`timescale 1ns/10ps
`default_nettype none

module wb_event_decode import ctrl_pkg::*; (
  // Instruction flags from the EX/WB pipeline register
  input  wire                 wb_instr_valid_i,
  input  wire                 wb_illegal_i,
  input  wire                 wb_ecall_i,
  input  wire                 wb_ebreak_i,
  input  wire                 wb_wfi_i,
  input  wire                 wb_mret_i,
  input  wire                 wb_dret_i,
  input  wire                 wb_lsu_en_i,

  // Qualified WB events
  output logic                exception_o,
  output logic [CAUSE_W-1:0]  exception_cause_o,
  output logic                wfi_o,
  output logic                mret_o,
  output logic                dret_o,
  output logic                ebreak_o,
  output logic                lsu_in_wb_o
);

  //////////////////////////////
  // Exception and cause
  //////////////////////////////

  always_comb begin
    // Any of the three trapping instructions, only for a live WB slot
    exception_o = wb_instr_valid_i && (wb_illegal_i || wb_ecall_i || wb_ebreak_i);

    // Fixed priority: illegal, then ecall, then ebreak
    if (wb_illegal_i) begin
      exception_cause_o = EXC_CAUSE_ILLEGAL_INSN;
    end else if (wb_ecall_i) begin
      exception_cause_o = EXC_CAUSE_ECALL_MMODE;
    end else if (wb_ebreak_i) begin
      exception_cause_o = EXC_CAUSE_BREAKPOINT;
    end else begin
      exception_cause_o = '0;
    end
  end

  // Other WB events, qualified with validity
  assign wfi_o       = wb_wfi_i    && wb_instr_valid_i;
  assign mret_o      = wb_mret_i   && wb_instr_valid_i;
  assign dret_o      = wb_dret_i   && wb_instr_valid_i;
  assign ebreak_o    = wb_ebreak_i && wb_instr_valid_i;
  // Load/store that still waits for its response
  assign lsu_in_wb_o = wb_lsu_en_i && wb_instr_valid_i;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the core controller testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f core_ctrl.f --top-module core_ctrl_tb \
  -Mdir "${BUILD}" -o core_ctrl_sim

"./${BUILD}/core_ctrl_sim" 2>&1 | tee "${LOG}"

if grep -q "Regression failed" "${LOG}"; then
  echo "Simulation failed, see ${LOG}"
  exit 1
fi
if ! grep -q "Regression passed" "${LOG}"; then
  echo "No pass line found in ${LOG}"
  exit 1
fi
echo "Simulation passed"

// File: verification/core_ctrl_vectors.svh
`ifndef CORE_CTRL_VECTORS_SVH
`define CORE_CTRL_VECTORS_SVH
`default_nettype none

// Stim: fetch_en dbg_req irq_req irq_wake _ irq_id _ wb valid ill ecall wfi dret mret lsu
//       _ if_iv id_iv ex_iv branch if_valid id_ready
// Exp:  req busy pc_set _ pc_mux _ exc_mux _ halt if..wb _ kill if..wb _ ack _ irq_id
//       _ csr_cause _ save if..wb _ restore_dret dbg_save dmode _ havereset running halted
//       _ save_cause restore_mret dbg_cause
task automatic load_vectors();
  // Boot, fetch stays off until enable
  add_row(22'b0000_00000_0000000_000000, 43'b010_000_01_0000_0000_0_00000_000000_0000_000_100_00011);
  add_row(22'b0000_00000_0000000_000000, 43'b010_000_01_0000_0000_0_00000_000000_0000_000_100_00011);
  add_row(22'b1000_00000_0000000_000000, 43'b010_000_01_0000_0000_0_00000_000000_0000_000_100_00011);
  // BOOT_SET with PC_BOOT, running one cycle later
  add_row(22'b1000_00000_0000000_111011, 43'b111_000_01_0000_0000_0_00000_000000_0000_000_100_00011);
  add_row(22'b1000_00000_0000000_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_000_010_00011);
  // Interrupt id 7, oldest valid is ID so the save lands on EX
  add_row(22'b1010_00111_0000000_110011, 43'b111_101_01_0000_1111_1_00111_100111_0010_000_010_10011);
  add_row(22'b1000_00000_0000000_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_000_010_00011);
  // Load/store in WB blocks the interrupt
  add_row(22'b1010_00011_1000001_111011, 43'b110_000_01_0100_0000_0_00000_000000_0000_000_010_00011);
  add_row(22'b1000_00000_0000000_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_000_010_00011);
  // Illegal with ecall, cause 2 wins and WB survives
  add_row(22'b1000_00000_1110000_111011, 43'b111_101_00_0000_1110_0_00000_000010_0001_000_010_10011);
  add_row(22'b1000_00000_0000000_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_000_010_00011);
  // Branch held two cycles, taken only once
  add_row(22'b1000_00000_0000000_111100, 43'b111_010_01_0000_1100_0_00000_000000_0000_000_010_00011);
  add_row(22'b1000_00000_0000000_111100, 43'b110_000_01_0000_0000_0_00000_000000_0000_000_010_00011);
  add_row(22'b1000_00000_0000000_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_000_010_00011);
  // WFI, then sleep until irq_wake_i
  add_row(22'b1000_00000_1001000_111011, 43'b010_000_01_1100_0000_0_00000_000000_0000_000_010_00011);
  add_row(22'b1000_00000_0000000_111011, 43'b000_000_01_0001_0000_0_00000_000000_0000_000_010_00011);
  add_row(22'b1000_00000_0000000_111011, 43'b000_000_01_0001_0000_0_00000_000000_0000_000_010_00011);
  add_row(22'b1001_00000_0000000_111011, 43'b000_000_01_0001_0000_0_00000_000000_0000_000_010_00011);
  add_row(22'b1000_00000_0000000_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_000_010_00011);
  // Debug request pulse halts all stages
  add_row(22'b1100_00000_0000000_111011, 43'b110_000_01_1111_0000_0_00000_000000_0000_000_010_00011);
  // DEBUG_TAKEN jumps to the halt vector
  add_row(22'b1000_00000_0000000_111011, 43'b111_101_10_0000_1111_0_00000_000000_0001_010_010_10011);
  add_row(22'b1000_00000_0000000_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_001_001_00011);
  add_row(22'b1000_00000_0000000_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_001_001_00011);
  // dret in WB, debug mode drops one cycle later
  add_row(22'b1000_00000_1000100_111011, 43'b111_100_01_0000_1110_0_00000_000000_0000_101_001_00011);
  add_row(22'b1000_00000_0000000_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_000_010_00011);
  add_row(22'b1000_00000_0000000_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_000_010_00011);
  // mret in WB restores mstatus outside debug mode
  add_row(22'b1000_00000_1000010_111011, 43'b110_000_01_0000_0000_0_00000_000000_0000_000_010_01011);
endtask

`default_nettype wire
`endif

// File: verification/core_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module core_ctrl_tb;

  // Bound on the whole run in clock cycles
  localparam int WATCHDOG_CYCLES = 200;

  logic        clk;
  logic        rst_n;

  // DUT inputs
  logic        fetch_enable_i;
  logic        jr_stall_i;
  logic        load_stall_i;
  logic        csr_stall_i;
  logic        jump_id_i;
  logic        mret_id_i;
  logic        if_instr_valid_i;
  logic        id_instr_valid_i;
  logic        ex_instr_valid_i;
  logic        branch_ex_i;
  logic        if_valid_i;
  logic        id_ready_i;
  logic        ex_valid_i;
  logic        wb_ready_i;
  logic        data_req_i;
  logic        wb_instr_valid_i;
  logic        wb_illegal_i;
  logic        wb_ecall_i;
  logic        wb_ebreak_i;
  logic        wb_wfi_i;
  logic        wb_mret_i;
  logic        wb_dret_i;
  logic        wb_lsu_en_i;
  logic        irq_req_i;
  logic [4:0]  irq_id_i;
  logic        irq_wake_i;
  logic        debug_req_i;
  logic        debug_ebreakm_i;

  // DUT outputs
  logic        instr_req_o;
  logic        ctrl_busy_o;
  logic        pc_set_o;
  logic [2:0]  pc_mux_o;
  logic [1:0]  exc_pc_mux_o;
  logic        halt_if_o;
  logic        halt_id_o;
  logic        halt_ex_o;
  logic        halt_wb_o;
  logic        kill_if_o;
  logic        kill_id_o;
  logic        kill_ex_o;
  logic        kill_wb_o;
  logic        irq_ack_o;
  logic [4:0]  irq_id_o;
  logic        csr_save_cause_o;
  logic [5:0]  csr_cause_o;
  logic        csr_save_if_o;
  logic        csr_save_id_o;
  logic        csr_save_ex_o;
  logic        csr_save_wb_o;
  logic        csr_restore_mret_o;
  logic        csr_restore_dret_o;
  logic        debug_csr_save_o;
  logic        debug_mode_o;
  logic [2:0]  debug_cause_o;
  logic        debug_havereset_o;
  logic        debug_running_o;
  logic        debug_halted_o;

  // Per-cycle table, one entry per row
  logic [21:0] stim_q [$];
  logic [42:0] exp_q  [$];
  logic [42:0] observed;
  int          error_count;

  core_ctrl_top DUT (.*);

  // Same column order as the expected part of a table row
  assign observed = {instr_req_o, ctrl_busy_o, pc_set_o, pc_mux_o, exc_pc_mux_o,
                     halt_if_o, halt_id_o, halt_ex_o, halt_wb_o,
                     kill_if_o, kill_id_o, kill_ex_o, kill_wb_o,
                     irq_ack_o, irq_id_o, csr_cause_o,
                     csr_save_if_o, csr_save_id_o, csr_save_ex_o, csr_save_wb_o,
                     csr_restore_dret_o, debug_csr_save_o, debug_mode_o,
                     debug_havereset_o, debug_running_o, debug_halted_o,
                     csr_save_cause_o, csr_restore_mret_o, debug_cause_o};

  //////////////////////////////
  // Clock and watchdog
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: vector table not finished after %0d cycles", WATCHDOG_CYCLES);
    stop_on_failure();
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic stop_on_failure();
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic add_row(input logic [21:0] stim, input logic [42:0] expected);
    stim_q.push_back(stim);
    exp_q.push_back(expected);
  endtask

  // Row inputs go out on the rising edge
  task automatic drive_row(input logic [21:0] stim);
    {fetch_enable_i, debug_req_i, irq_req_i, irq_wake_i, irq_id_i,
     wb_instr_valid_i, wb_illegal_i, wb_ecall_i, wb_wfi_i, wb_dret_i, wb_mret_i,
     wb_lsu_en_i,
     if_instr_valid_i, id_instr_valid_i, ex_instr_valid_i, branch_ex_i,
     if_valid_i, id_ready_i} <= stim;
  endtask

  task automatic check_row(input int row);
    assert (observed === exp_q[row]) else begin
      error_count++;
      $display("MISMATCH at %0t: row %0d got %b expected %b",
               $time, row, observed, exp_q[row]);
      stop_on_failure();
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    // Reset held from time zero, every input idle
    rst_n = 1'b0;
    {fetch_enable_i, debug_req_i, irq_req_i, irq_wake_i, irq_id_i} = '0;
    {wb_instr_valid_i, wb_illegal_i, wb_ecall_i, wb_wfi_i, wb_dret_i, wb_mret_i} = '0;
    wb_lsu_en_i = 1'b0;
    {if_instr_valid_i, id_instr_valid_i, ex_instr_valid_i, branch_ex_i} = '0;
    {if_valid_i, id_ready_i} = '0;
    // Held low for the whole run
    {jr_stall_i, load_stall_i, csr_stall_i, jump_id_i, mret_id_i} = '0;
    {ex_valid_i, wb_ready_i, data_req_i, wb_ebreak_i, debug_ebreakm_i} = '0;
    error_count = 0;
    load_vectors();

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Outputs sampled at the falling edge, settled by then
    for (int row = 0; row < stim_q.size(); row++) begin
      @(posedge clk);
      drive_row(stim_q[row]);
      @(negedge clk);
      check_row(row);
    end

    @(posedge clk);
    if (error_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_on_failure();
    end
  end

  `include "core_ctrl_vectors.svh"

endmodule

`default_nettype wire
